// File: tb.f
+incdir+source
source/cache_pkg.sv
source/cache_req_stage.sv
source/tag_data_store.sv
source/tag_data_access.sv
source/cache_bank.sv
tb/cache_bank_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module cache_bank_tb \
    -f tb.f -o cache_bank_sim

out=$(./obj_dir/cache_bank_sim) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1

// File: tb/cache_bank_tb.sv
`include "cache_params.svh"

module cache_bank_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY        = 1 + `STAGE_1_CYCLES;
    localparam int TIMEOUT_CYCLES = 40;

    typedef struct {
        cache_pkg::req_op_t     op;
        cache_pkg::word_addr_t  addr;
        cache_pkg::word_t       wdata;
        cache_pkg::byteen_t     byteen;
        logic [31:0]            seed;
        logic                   exp_resp;
        logic                   exp_miss;
        cache_pkg::word_t       exp_rdata;
        logic                   exp_evict;
        cache_pkg::tag_t        evict_tag;
        logic [31:0]            evict_seed;
        logic                   back_to_back;
        int                     stall_cycles;
    } entry_t;

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic                   req_valid;
    cache_pkg::req_op_t     req_op;
    cache_pkg::word_addr_t  req_addr;
    cache_pkg::word_t       req_wdata;
    cache_pkg::byteen_t     req_byteen;
    cache_pkg::line_t       req_fill_data;
    logic                   resp_valid;
    logic                   resp_miss;
    cache_pkg::word_t       resp_rdata;
    logic                   evict_valid;
    cache_pkg::tag_t        evict_tag;
    cache_pkg::line_t       evict_data;

    entry_t tbl[$];

    cache_bank dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Fill words come from the generator one step per word
    function automatic cache_pkg::line_t fill_line(logic [31:0] seed);
        cache_pkg::line_t data;
        logic [31:0]      state;
        state = 32'h329d ^ seed;
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            state = lcg_next(state);
            data[w*`WORD_WIDTH +: `WORD_WIDTH] = state;
        end
        return data;
    endfunction

    // Most recent fill before entry n that really loaded this line and tag
    function automatic int last_fill(int n, cache_pkg::line_sel_t line, cache_pkg::tag_t tag);
        int found;
        found = -1;
        for (int j = 0; j < n; j++) begin
            if (tbl[j].op == cache_pkg::op_fill && tbl[j].exp_miss == 1'b1 &&
                    tbl[j].addr.fields.line_sel == line && tbl[j].addr.fields.tag == tag) begin
                found = j;
            end
        end
        return found;
    endfunction

    // Write hits between that fill and entry n merged byte by byte
    function automatic cache_pkg::line_t apply_writes(int n, cache_pkg::line_sel_t line,
                                                      cache_pkg::tag_t tag, int from,
                                                      cache_pkg::line_t base);
        cache_pkg::line_t data;
        int               pos;
        data = base;
        for (int j = from + 1; j < n; j++) begin
            if (tbl[j].op == cache_pkg::op_write && tbl[j].exp_miss == 1'b0 &&
                    tbl[j].addr.fields.line_sel == line && tbl[j].addr.fields.tag == tag) begin
                for (int b = 0; b < `WORD_SIZE; b++) begin
                    pos = int'(tbl[j].addr.fields.word_sel) * `WORD_SIZE + b;
                    if (tbl[j].byteen[b]) begin
                        data[pos*8 +: 8] = tbl[j].wdata[b*8 +: 8];
                    end
                end
            end
        end
        return data;
    endfunction

    task automatic add(cache_pkg::req_op_t op, int tag, int line, int word, int wdata,
                       int byteen, int seed, int miss, int evict, int etag, int eseed,
                       int b2b, int stall_n);
        entry_t           e;
        cache_pkg::line_t data;
        int               idx;
        e.op                   = op;
        e.addr.fields.tag      = cache_pkg::tag_t'(tag);
        e.addr.fields.line_sel = cache_pkg::line_sel_t'(line);
        e.addr.fields.word_sel = cache_pkg::word_sel_t'(word);
        e.wdata        = cache_pkg::word_t'(wdata);
        e.byteen       = cache_pkg::byteen_t'(byteen);
        e.seed         = 32'(seed);
        e.exp_resp     = (op != cache_pkg::op_fill);
        e.exp_miss     = (miss != 0);
        e.exp_rdata    = '0;
        e.exp_evict    = (evict != 0);
        e.evict_tag    = cache_pkg::tag_t'(etag);
        e.evict_seed   = 32'(eseed);
        e.back_to_back = (b2b != 0);
        e.stall_cycles = stall_n;
        if (op == cache_pkg::op_read && miss == 0) begin
            idx  = last_fill(tbl.size(), e.addr.fields.line_sel, e.addr.fields.tag);
            data = apply_writes(tbl.size(), e.addr.fields.line_sel, e.addr.fields.tag, idx,
                                fill_line(tbl[idx].seed));
            e.exp_rdata = data[int'(e.addr.fields.word_sel)*`WORD_WIDTH +: `WORD_WIDTH];
        end
        tbl.push_back(e);
    endtask

    task automatic add_read(int tag, int line, int word, int miss, int b2b = 0,
                            int stall_n = 0);
        add(cache_pkg::op_read, tag, line, word, 0, 0, 0, miss, 0, 0, 0, b2b, stall_n);
    endtask

    task automatic add_write(int tag, int line, int word, int wdata, int byteen, int miss,
                             int b2b = 0, int stall_n = 0);
        add(cache_pkg::op_write, tag, line, word, wdata, byteen, 0, miss, 0, 0, 0, b2b, stall_n);
    endtask

    task automatic add_fill(int tag, int line, int seed, int miss, int evict = 0,
                            int etag = 0, int eseed = 0);
        add(cache_pkg::op_fill, tag, line, 0, 0, 0, seed, miss, evict, etag, eseed, 0, 0);
    endtask

    task automatic build_table();
        for (int l = 0; l < `NUM_LINES; l++) begin
            add_read('h1, l, l % `WORDS_PER_LINE, 1);
        end
        add_fill('ha1, 5, 1, 1);
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            add_read('ha1, 5, w, 0);
        end
        add_write('ha1, 5, 2, 'hdeadbeef, 'b0101, 0);
        add_read('ha1, 5, 2, 0);
        add_write('h33, 9, 1, 'h11223344, 'hf, 1);
        add_read('h33, 9, 1, 1);
        add_fill('h33, 9, 2, 1);
        add_read('h33, 9, 1, 0);
        // Dirty line 5 goes out, clean line 9 does not
        add_fill('hb2, 5, 3, 1, 1, 'ha1, 1);
        add_read('ha1, 5, 2, 1);
        add_read('hb2, 5, 0, 0);
        add_fill('h44, 9, 4, 1);
        add_fill('h44, 9, 5, 0);
        add_read('h44, 9, 3, 0);
        add_fill('h77, 12, 6, 1);
        add_write('h77, 12, 1, 'h12345678, 'hf, 0);
        add_read('h77, 12, 1, 0, 1);
        add_write('h77, 12, 1, 'habcdef01, 'b0011, 0);
        add_read('h77, 12, 1, 0, 1);
        add_fill('h78, 12, 7, 1, 1, 'h77, 6);
        add_read('h78, 12, 2, 0, 1);
        add_write('h78, 12, 3, 'h55aa55aa, 'b1000, 0);
        add_write('h78, 12, 3, 'h0f0f0f0f, 'b0001, 0, 1);
        add_read('h78, 12, 3, 0, 1);
        add_read('h78, 12, 3, 0, 0, 4);
        add_read('h78, 12, 3, 0);
        add_write('h78, 12, 0, 'hcafef00d, 'hf, 0, 0, 3);
        add_read('h78, 12, 0, 0);
        add_read('h33, 9, 1, 1);
        add_fill('h100, 20, 8, 1);
        add_read('h101, 20, 0, 1);
        add_write('h101, 20, 0, 'h99999999, 'hf, 1);
        add_read('h100, 20, 0, 0);
    endtask

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(string name, cache_pkg::word_t got, cache_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_tag(string name, cache_pkg::tag_t got, cache_pkg::tag_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(string name, cache_pkg::line_t got, cache_pkg::line_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic expect_pulse(string name, int n, logic seen, logic due);
        if (due && seen !== 1'b1) begin
            $display("Entry %0d: expected a pulse on %s, none came", n, name);
            abort_run();
        end else if (!due && seen !== 1'b0) begin
            $display("Entry %0d: %s pulsed where none was due", n, name);
            abort_run();
        end
    endtask

    task automatic check_entry(int n);
        cache_pkg::line_sel_t line;
        int                   idx;
        line = tbl[n].addr.fields.line_sel;
        expect_pulse("resp_valid", n, resp_valid, tbl[n].exp_resp);
        expect_pulse("evict_valid", n, evict_valid, tbl[n].exp_evict);
        if (tbl[n].exp_resp) begin
            check_bit("resp_miss", resp_miss, tbl[n].exp_miss);
            if (tbl[n].op == cache_pkg::op_read) begin
                check_word("resp_rdata", resp_rdata, tbl[n].exp_rdata);
            end
        end
        if (tbl[n].exp_evict) begin
            check_tag("evict_tag", evict_tag, tbl[n].evict_tag);
            idx = last_fill(n, line, tbl[n].evict_tag);
            check_line("evict_data", evict_data,
                       apply_writes(n, line, tbl[n].evict_tag, idx,
                                    fill_line(tbl[n].evict_seed)));
        end
    endtask

    task automatic drive_entry(int n);
        req_valid     = 1'b1;
        req_op        = tbl[n].op;
        req_addr      = tbl[n].addr;
        req_wdata     = tbl[n].wdata;
        req_byteen    = tbl[n].byteen;
        req_fill_data = fill_line(tbl[n].seed);
    endtask

    // Issues entries one per cycle and checks each in its own response slot
    task automatic run_group(int first, int count);
        int   stall_n;
        int   offset;
        logic done;
        stall_n = tbl[first].stall_cycles;
        done    = 1'b0;
        drive_entry(first);
        for (int k = 1; k <= TIMEOUT_CYCLES && !done; k++) begin
            @(negedge clk);
            offset = k - LATENCY - stall_n;
            if (offset >= 0 && offset < count) begin
                check_entry(first + offset);
                done = (offset == count - 1);
            end else if (resp_valid !== 1'b0 || evict_valid !== 1'b0) begin
                $display("Entry %0d: pulse outside its slot at cycle %0d", first, k);
                abort_run();
            end
            if (k < count) begin
                drive_entry(first + k);
            end else if (k == count) begin
                req_valid = 1'b0;
                if (stall_n > 0) begin
                    // Offered while stalled, so it must never land
                    stall      = 1'b1;
                    req_valid  = 1'b1;
                    req_op     = cache_pkg::op_write;
                    req_wdata  = ~tbl[first].wdata;
                    req_byteen = '1;
                end
            end else if (k == count + stall_n) begin
                stall     = 1'b0;
                req_valid = 1'b0;
            end
        end
        if (!done) begin
            $display("Entry %0d: timed out waiting for its response", first);
            abort_run();
        end
    endtask

    initial begin
        int i;
        int n;
        reset         = 1'b1;
        stall         = 1'b0;
        req_valid     = 1'b0;
        req_op        = cache_pkg::op_read;
        req_addr      = '0;
        req_wdata     = '0;
        req_byteen    = '0;
        req_fill_data = '0;
        build_table();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        // Valid and dirty sweep
        repeat (`NUM_LINES) @(negedge clk);
        i = 0;
        while (i < tbl.size()) begin
            n = 1;
            while (i + n < tbl.size() && tbl[i + n].back_to_back) begin
                n++;
            end
            run_group(i, n);
            i += n;
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: source/cache_bank.sv
`include "cache_params.svh"

module cache_bank (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,

    input  logic                   req_valid,
    input  cache_pkg::req_op_t     req_op,
    input  cache_pkg::word_addr_t  req_addr,
    input  cache_pkg::word_t       req_wdata,
    input  cache_pkg::byteen_t     req_byteen,
    input  cache_pkg::line_t       req_fill_data,

    output logic                   resp_valid,
    output logic                   resp_miss,
    output cache_pkg::word_t       resp_rdata,

    output logic                   evict_valid,
    output cache_pkg::tag_t        evict_tag,
    output cache_pkg::line_t       evict_data
);

    // Request stage to access stage
    logic                     st0_valid;
    cache_pkg::req_op_t       st0_op;
    cache_pkg::word_addr_t    st0_addr;
    cache_pkg::word_t         st0_wdata;
    cache_pkg::byteen_t       st0_byteen;
    cache_pkg::line_t         st0_fill_data;
    cache_pkg::line_sel_t     read_line;

    // Store read result
    logic                     rd_valid;
    logic                     rd_dirty;
    cache_pkg::tag_t          rd_tag;
    cache_pkg::line_t         rd_data;

    // Store write port
    cache_pkg::line_sel_t     wr_line;
    cache_pkg::tag_t          wr_tag;
    cache_pkg::line_byteen_t  wr_enable;
    cache_pkg::line_t         wr_data;
    logic                     wr_fill;

    cache_req_stage req_stage (.*);

    tag_data_store store (.*);

    tag_data_access access (.*);

endmodule

// File: source/tag_data_access.sv
`include "cache_params.svh"

module tag_data_access (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,

    input  logic                      st0_valid,
    input  cache_pkg::req_op_t        st0_op,
    input  cache_pkg::word_addr_t     st0_addr,
    input  cache_pkg::word_t          st0_wdata,
    input  cache_pkg::byteen_t        st0_byteen,
    input  cache_pkg::line_t          st0_fill_data,

    input  logic                      rd_valid,
    input  logic                      rd_dirty,
    input  cache_pkg::tag_t           rd_tag,
    input  cache_pkg::line_t          rd_data,

    output cache_pkg::line_sel_t      wr_line,
    output cache_pkg::tag_t           wr_tag,
    output cache_pkg::line_byteen_t   wr_enable,
    output cache_pkg::line_t          wr_data,
    output logic                      wr_fill,

    output logic                      resp_valid,
    output logic                      resp_miss,
    output cache_pkg::word_t          resp_rdata,

    output logic                      evict_valid,
    output cache_pkg::tag_t           evict_tag,
    output cache_pkg::line_t          evict_data
);

    localparam int RD_W = 2 + `TAG_BITS + `LINE_WIDTH;

    logic                   s1_valid     [`STAGE_1_CYCLES];
    cache_pkg::req_op_t     s1_op        [`STAGE_1_CYCLES];
    cache_pkg::word_addr_t  s1_addr      [`STAGE_1_CYCLES];
    cache_pkg::word_t       s1_wdata     [`STAGE_1_CYCLES];
    cache_pkg::byteen_t     s1_byteen    [`STAGE_1_CYCLES];
    cache_pkg::line_t       s1_fill_data [`STAGE_1_CYCLES];

    logic [RD_W-1:0]        rd_pack;
    logic [RD_W-1:0]        rd_use;

    logic                   use_valid;
    logic                   use_dirty;
    cache_pkg::tag_t        use_tag;
    cache_pkg::line_t       use_data;

    logic                   req_valid;
    cache_pkg::word_addr_t  req_addr;
    logic                   is_fill;
    logic                   miss;
    logic                   real_fill;
    logic                   write_hit;

    // Request travels alongside the store read
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `STAGE_1_CYCLES; i++) begin
                s1_valid[i] <= 1'b0;
            end
        end else if (!stall) begin
            s1_valid[0] <= st0_valid;
            for (int i = 1; i < `STAGE_1_CYCLES; i++) begin
                s1_valid[i] <= s1_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_op[0]        <= st0_op;
            s1_addr[0]      <= st0_addr;
            s1_wdata[0]     <= st0_wdata;
            s1_byteen[0]    <= st0_byteen;
            s1_fill_data[0] <= st0_fill_data;
            for (int i = 1; i < `STAGE_1_CYCLES; i++) begin
                s1_op[i]        <= s1_op[i-1];
                s1_addr[i]      <= s1_addr[i-1];
                s1_wdata[i]     <= s1_wdata[i-1];
                s1_byteen[i]    <= s1_byteen[i-1];
                s1_fill_data[i] <= s1_fill_data[i-1];
            end
        end
    end

    assign rd_pack = {rd_valid, rd_dirty, rd_tag, rd_data};

    // The store already spends one cycle on its read
    if (`STAGE_1_CYCLES > 1) begin : g_rd_delay
        logic [RD_W-1:0] rd_d [`STAGE_1_CYCLES-1];

        always_ff @(posedge clk) begin
            if (!stall) begin
                rd_d[0] <= rd_pack;
                for (int i = 1; i < `STAGE_1_CYCLES - 1; i++) begin
                    rd_d[i] <= rd_d[i-1];
                end
            end
        end

        assign rd_use = rd_d[`STAGE_1_CYCLES-2];
    end else begin : g_rd_direct
        assign rd_use = rd_pack;
    end

    assign {use_valid, use_dirty, use_tag, use_data} = rd_use;

    assign req_valid = s1_valid[`STAGE_1_CYCLES-1];
    assign req_addr  = s1_addr[`STAGE_1_CYCLES-1];
    assign is_fill   = s1_op[`STAGE_1_CYCLES-1] == cache_pkg::op_fill;

    assign miss      = !use_valid || (use_tag != req_addr.fields.tag);
    // Fill of a line that already holds this tag leaves it alone
    assign real_fill = req_valid && is_fill && miss;
    assign write_hit = req_valid && (s1_op[`STAGE_1_CYCLES-1] == cache_pkg::op_write) && !miss;

    always_comb begin
        wr_enable = '0;
        wr_data   = '0;
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            if (real_fill) begin
                wr_enable[w*`WORD_SIZE +: `WORD_SIZE] = '1;
                wr_data[w*`WORD_WIDTH +: `WORD_WIDTH] =
                    s1_fill_data[`STAGE_1_CYCLES-1][w*`WORD_WIDTH +: `WORD_WIDTH];
            end else begin
                wr_data[w*`WORD_WIDTH +: `WORD_WIDTH] = s1_wdata[`STAGE_1_CYCLES-1];
                if (write_hit && req_addr.fields.word_sel == cache_pkg::word_sel_t'(w)) begin
                    wr_enable[w*`WORD_SIZE +: `WORD_SIZE] = s1_byteen[`STAGE_1_CYCLES-1];
                end
            end
        end
    end

    assign wr_line = req_addr.fields.line_sel;
    assign wr_tag  = req_addr.fields.tag;
    assign wr_fill = real_fill;

    assign resp_valid = req_valid && !is_fill && !stall;
    assign resp_miss  = miss;
    assign resp_rdata = miss ? '0 :
                        use_data[req_addr.fields.word_sel*`WORD_WIDTH +: `WORD_WIDTH];

    // Displaced dirty line goes back to memory
    assign evict_valid = real_fill && use_valid && use_dirty && !stall;
    assign evict_tag   = use_tag;
    assign evict_data  = use_data;

endmodule

// File: source/tag_data_store.sv
`include "cache_params.svh"

module tag_data_store (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,

    input  cache_pkg::line_sel_t      read_line,

    input  cache_pkg::line_sel_t      wr_line,
    input  cache_pkg::tag_t           wr_tag,
    input  cache_pkg::line_byteen_t   wr_enable,
    input  cache_pkg::line_t          wr_data,
    input  logic                      wr_fill,

    output logic                      rd_valid,
    output logic                      rd_dirty,
    output cache_pkg::tag_t           rd_tag,
    output cache_pkg::line_t          rd_data
);

    logic              valid_arr [`NUM_LINES];
    logic              dirty_arr [`NUM_LINES];
    cache_pkg::tag_t   tag_arr   [`NUM_LINES];
    cache_pkg::line_t  data_arr  [`NUM_LINES];

    logic                  init_busy;
    cache_pkg::line_sel_t  init_line;

    logic                  fwd_valid;
    logic                  fwd_dirty;
    cache_pkg::tag_t       fwd_tag;
    cache_pkg::line_t      fwd_data;

    // Valid and dirty are swept clear one line per cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            init_busy <= 1'b1;
            init_line <= '0;
        end else if (init_busy) begin
            valid_arr[init_line] <= 1'b0;
            dirty_arr[init_line] <= 1'b0;
            init_line <= init_line + 1'b1;
            if (init_line == cache_pkg::line_sel_t'(`NUM_LINES - 1)) begin
                init_busy <= 1'b0;
            end
        end else if (!stall) begin
            if (wr_fill) begin
                valid_arr[wr_line] <= 1'b1;
                dirty_arr[wr_line] <= 1'b0;
            end else if (|wr_enable) begin
                dirty_arr[wr_line] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (wr_fill) begin
                tag_arr[wr_line] <= wr_tag;
            end
            for (int b = 0; b < `LINE_SIZE; b++) begin
                if (wr_enable[b]) begin
                    data_arr[wr_line][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // Same-cycle write to the line being read wins over the array contents
    always_comb begin
        fwd_valid = valid_arr[read_line];
        fwd_dirty = dirty_arr[read_line];
        fwd_tag   = tag_arr[read_line];
        fwd_data  = data_arr[read_line];
        if (wr_line == read_line) begin
            if (wr_fill) begin
                fwd_valid = 1'b1;
                fwd_dirty = 1'b0;
                fwd_tag   = wr_tag;
            end else if (|wr_enable) begin
                fwd_dirty = 1'b1;
            end
            for (int b = 0; b < `LINE_SIZE; b++) begin
                if (wr_enable[b]) begin
                    fwd_data[b*8 +: 8] = wr_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rd_valid <= fwd_valid;
            rd_dirty <= fwd_dirty;
            rd_tag   <= fwd_tag;
            rd_data  <= fwd_data;
        end
    end

endmodule

// File: source/cache_req_stage.sv
`include "cache_params.svh"

module cache_req_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,

    input  logic                   req_valid,
    input  cache_pkg::req_op_t     req_op,
    input  cache_pkg::word_addr_t  req_addr,
    input  cache_pkg::word_t       req_wdata,
    input  cache_pkg::byteen_t     req_byteen,
    input  cache_pkg::line_t       req_fill_data,

    output logic                   st0_valid,
    output cache_pkg::req_op_t     st0_op,
    output cache_pkg::word_addr_t  st0_addr,
    output cache_pkg::word_t       st0_wdata,
    output cache_pkg::byteen_t     st0_byteen,
    output cache_pkg::line_t       st0_fill_data,

    output cache_pkg::line_sel_t   read_line
);

    cache_pkg::word_addr_t  addr_in;
    logic                   accept;

    assign accept = req_valid && !stall;

    // A fill covers the whole line, so the word select carries no meaning
    always_comb begin
        addr_in = req_addr;
        if (req_op == cache_pkg::op_fill) begin
            addr_in.fields.word_sel = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
        end else if (!stall) begin
            st0_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            st0_op        <= req_op;
            st0_addr      <= addr_in;
            st0_wdata     <= req_wdata;
            st0_byteen    <= req_byteen;
            st0_fill_data <= req_fill_data;
        end
    end

    // Store read is indexed by the held request
    assign read_line = st0_addr.fields.line_sel;

endmodule

// File: source/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`TAG_BITS-1:0]      tag_t;
    typedef logic [`LINE_SEL_BITS-1:0] line_sel_t;
    typedef logic [`WORD_SEL_BITS-1:0] word_sel_t;

    typedef logic [`WORD_WIDTH-1:0]    word_t;
    typedef logic [`LINE_WIDTH-1:0]    line_t;
    typedef logic [`WORD_SIZE-1:0]     byteen_t;
    typedef logic [`LINE_SIZE-1:0]     line_byteen_t;

    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_fill  = 2'd2
    } req_op_t;

    // Tag in the upper bits, word select in the lower bits
    typedef struct packed {
        tag_t      tag;
        line_sel_t line_sel;
        word_sel_t word_sel;
    } addr_fields_t;

    typedef union packed {
        logic [`ADDR_WIDTH-1:0] raw;
        addr_fields_t           fields;
    } word_addr_t;

endpackage

// File: source/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Bank geometry in bytes
`define CACHE_SIZE      1024
`define LINE_SIZE       16
`define WORD_SIZE       4

// Word address width as seen on the request port
`define ADDR_WIDTH      24

// Cycles from the store read to the hit/miss decision
`define STAGE_1_CYCLES  1

`define NUM_LINES       (`CACHE_SIZE / `LINE_SIZE)
`define WORDS_PER_LINE  (`LINE_SIZE / `WORD_SIZE)

`define LINE_SEL_BITS   $clog2(`NUM_LINES)
`define WORD_SEL_BITS   $clog2(`WORDS_PER_LINE)
`define TAG_BITS        (`ADDR_WIDTH - `LINE_SEL_BITS - `WORD_SEL_BITS)

`define WORD_WIDTH      (`WORD_SIZE * 8)
`define LINE_WIDTH      (`LINE_SIZE * 8)

`endif
